// ==== cp0_defs.svh ====
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// cp0 register numbers
`define CP0_INDEX     5'd0
`define CP0_ENTRYLO0  5'd2
`define CP0_ENTRYLO1  5'd3
`define CP0_BADVADDR  5'd8
`define CP0_COUNT     5'd9
`define CP0_ENTRYHI   5'd10
`define CP0_COMPARE   5'd11
`define CP0_STATUS    5'd12
`define CP0_CAUSE     5'd13
`define CP0_EPC       5'd14
`define CP0_CONFIG    5'd16

// cause.exccode values
`define EXC_INT   5'd0
`define EXC_MOD   5'd1
`define EXC_TLBL  5'd2
`define EXC_TLBS  5'd3
`define EXC_ADEL  5'd4
`define EXC_ADES  5'd5

`define TLBNUM     16
`define TLB_IDX_W  4

// cache geometry, only reported through config1
`define I_WAYS        2
`define I_LINE_BYTES  32
`define I_LINES       128
`define D_WAYS        2
`define D_LINE_BYTES  16
`define D_LINES       256

`endif

// ==== cp0_pkg.sv ====
`default_nettype none

`include "cp0_defs.svh"

package cp0_pkg;

    // one move-to/move-from access from the pipeline
    typedef struct packed {
        logic [4:0]  reg_num;
        logic [2:0]  sel;
        logic        wen;
        logic [31:0] wdata;
    } cp0_access_t;

    // one page half of a tlb entry, same bit order as entrylo
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlb_page_t;

    // lo[0] is the even page, lo[1] the odd page
    typedef struct packed {
        logic [18:0]     vpn2;
        logic [7:0]      asid;
        logic            g;
        tlb_page_t [1:0] lo;
    } tlb_entry_t;

    typedef struct packed {
        logic                  hit;
        logic [`TLB_IDX_W-1:0] index;
        logic [19:0]           pfn;
        logic [2:0]            c;
        logic                  d;
        logic                  v;
    } tlb_result_t;

    typedef struct packed {
        logic        valid;
        logic        store;
        logic        size_word;
        logic [31:0] vaddr;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic        eret;
        logic [4:0]  exccode;
        logic [31:0] badvaddr;
        logic [18:0] vpn2;
        logic [31:0] pc;
        logic        delay_slot;
    } exc_event_t;

    typedef struct packed {
        logic probe;
        logic read;
        logic write_indexed;
    } tlb_op_t;

endpackage

`default_nettype wire

// ==== cp0_regs.sv ====
`default_nettype none

`include "cp0_defs.svh"

module cp0_regs
    import cp0_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire cp0_access_t       acc,
    input  wire exc_event_t        exc_event,
    input  wire [5:0]              interrupt,
    input  wire tlb_op_t           tlb_op,
    input  wire tlb_result_t       probe,
    input  wire tlb_entry_t        rd_entry,
    output logic [31:0]            rdata,
    output logic [31:0]            epc,
    output logic                   status_exl,
    output logic                   status_ie,
    output logic [7:0]             status_im,
    output logic [7:0]             cause_ip,
    output logic [7:0]             asid,
    output tlb_entry_t             wr_entry,
    output logic                   wr_en,
    output logic [`TLB_IDX_W-1:0]  tlb_index,
    output logic                   exception_now,
    output logic                   eret_now
);

    // config1 fields
    localparam logic [5:0] mmu_size = 6'(`TLBNUM - 1);
    localparam logic [2:0] c1_is = 3'($clog2(`I_LINES) - 6);
    localparam logic [2:0] c1_il = 3'($clog2(`I_LINE_BYTES) - 1);
    localparam logic [2:0] c1_ia = 3'(`I_WAYS - 1);
    localparam logic [2:0] c1_ds = 3'($clog2(`D_LINES) - 6);
    localparam logic [2:0] c1_dl = 3'($clog2(`D_LINE_BYTES) - 1);
    localparam logic [2:0] c1_da = 3'(`D_WAYS - 1);
    localparam logic [31:0] config1 = {
        1'b0, mmu_size, c1_is, c1_il, c1_ia, c1_ds, c1_dl, c1_da, 7'b0
    };

    logic                  exc_take;
    logic                  eret_take;
    logic                  tlb_exc;
    logic                  index_p;
    logic [`TLB_IDX_W-1:0] index_idx;
    tlb_page_t [1:0]       entry_lo;
    logic [1:0]            entry_lo_g;
    logic [18:0]           entry_hi_vpn2;
    logic [7:0]            entry_hi_asid;
    logic                  cause_bd;
    logic                  cause_ti;
    logic [4:0]            cause_exccode;
    logic [31:0]           badvaddr;
    logic [31:0]           count;
    logic [31:0]           compare;
    logic                  count_tick;
    logic [2:0]            config_k0;
    logic [31:0]           config0;

    function automatic logic mtc0(input logic [4:0] num);
        return acc.wen && acc.sel == 3'd0 && acc.reg_num == num;
    endfunction

    assign exc_take  = exc_event.valid && !exc_event.eret;
    assign eret_take = exc_event.valid && exc_event.eret;
    assign tlb_exc   = exc_take && (exc_event.exccode == `EXC_TLBL ||
                                    exc_event.exccode == `EXC_TLBS ||
                                    exc_event.exccode == `EXC_MOD);

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p   <= 1'b0;
            index_idx <= '0;
        end else if (tlb_op.probe) begin
            index_p   <= !probe.hit;
            index_idx <= probe.index;
        end else if (mtc0(`CP0_INDEX)) begin
            index_idx <= acc.wdata[`TLB_IDX_W-1:0];
        end
    end

    // entrylo layout is pfn, c, d, v, g from bit 25 down
    always_ff @(posedge clk) begin
        if (tlb_op.read) begin
            entry_lo   <= rd_entry.lo;
            entry_lo_g <= {2{rd_entry.g}};
        end else begin
            if (mtc0(`CP0_ENTRYLO0)) begin
                {entry_lo[0], entry_lo_g[0]} <= acc.wdata[25:0];
            end
            if (mtc0(`CP0_ENTRYLO1)) begin
                {entry_lo[1], entry_lo_g[1]} <= acc.wdata[25:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_exc) begin
            entry_hi_vpn2 <= exc_event.vpn2;
        end else if (tlb_op.read) begin
            entry_hi_vpn2 <= rd_entry.vpn2;
            entry_hi_asid <= rd_entry.asid;
        end else if (mtc0(`CP0_ENTRYHI)) begin
            entry_hi_vpn2 <= acc.wdata[31:13];
            entry_hi_asid <= acc.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
            status_im  <= '0;
        end else if (eret_take) begin
            status_exl <= 1'b0;
        end else if (exc_take) begin
            status_exl <= 1'b1;
        end else if (mtc0(`CP0_STATUS)) begin
            status_im  <= acc.wdata[15:8];
            status_exl <= acc.wdata[1];
            status_ie  <= acc.wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd      <= 1'b0;
            cause_exccode <= `EXC_INT;
        end else if (exc_take) begin
            // nested exception keeps the original bd
            if (!status_exl) begin
                cause_bd <= exc_event.delay_slot;
            end
            cause_exccode <= exc_event.exccode;
        end
    end

    // timer interrupt flag
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ti <= 1'b0;
        end else if (mtc0(`CP0_COMPARE)) begin
            cause_ti <= 1'b0;
        end else if (count == compare) begin
            cause_ti <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ip <= '0;
        end else begin
            cause_ip[7]   <= interrupt[5] || cause_ti;
            cause_ip[6:2] <= interrupt[4:0];
            if (mtc0(`CP0_CAUSE)) begin
                cause_ip[1:0] <= acc.wdata[9:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_take && !status_exl) begin
            epc <= exc_event.delay_slot ? exc_event.pc - 32'd4 : exc_event.pc;
        end else if (mtc0(`CP0_EPC)) begin
            epc <= acc.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (exc_take) begin
            badvaddr <= exc_event.badvaddr;
        end
    end

    // count runs at half the core clock
    always_ff @(posedge clk) begin
        if (reset) begin
            count_tick <= 1'b1;
            count      <= '0;
        end else begin
            count_tick <= !count_tick;
            if (mtc0(`CP0_COUNT)) begin
                count <= acc.wdata;
            end else if (count_tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mtc0(`CP0_COMPARE)) begin
            compare <= acc.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            config_k0 <= 3'd2;
        end else if (mtc0(`CP0_CONFIG)) begin
            config_k0 <= acc.wdata[2:0];
        end
    end

    // M set, little endian, MIPS32 R1, standard tlb
    assign config0 = {1'b1, 15'b0, 1'b0, 2'b0, 3'b0, 3'd1, 4'b0, config_k0};

    always_comb begin
        case (acc.reg_num)
            `CP0_INDEX:    rdata = {index_p, {(31 - `TLB_IDX_W){1'b0}}, index_idx};
            `CP0_ENTRYLO0: rdata = {6'b0, entry_lo[0], entry_lo_g[0]};
            `CP0_ENTRYLO1: rdata = {6'b0, entry_lo[1], entry_lo_g[1]};
            `CP0_BADVADDR: rdata = badvaddr;
            `CP0_COUNT:    rdata = count;
            `CP0_ENTRYHI:  rdata = {entry_hi_vpn2, 5'b0, entry_hi_asid};
            `CP0_COMPARE:  rdata = compare;
            `CP0_STATUS:   rdata = {9'b0, 1'b1, 6'b0, status_im, 6'b0, status_exl, status_ie};
            `CP0_CAUSE:    rdata = {cause_bd, cause_ti, 14'b0, cause_ip, 1'b0, cause_exccode, 2'b0};
            `CP0_EPC:      rdata = epc;
            `CP0_CONFIG: begin
                case (acc.sel)
                    3'd0:    rdata = config0;
                    3'd1:    rdata = config1;
                    default: rdata = '0;
                endcase
            end
            default:       rdata = '0;
        endcase
    end

    assign asid          = entry_hi_asid;
    assign wr_entry      = {entry_hi_vpn2, entry_hi_asid, &entry_lo_g, entry_lo};
    assign wr_en         = tlb_op.write_indexed;
    assign tlb_index     = index_idx;
    assign exception_now = exc_take;
    assign eret_now      = eret_take;

    // the prioritizer drops an eret that meets a memory fault
    a_exc_eret_excl: assert property (@(posedge clk) disable iff (reset)
        exc_event.eret |-> exc_event.valid && exc_event.exccode == `EXC_INT);

    // read and write share the index register
    a_tlb_rw_excl: assert property (@(posedge clk) disable iff (reset)
        !(tlb_op.read && tlb_op.write_indexed));

endmodule

`default_nettype wire

// ==== tlb.sv ====
`default_nettype none

`include "cp0_defs.svh"

module tlb
    import cp0_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire [31:0]            vaddr,
    input  wire [7:0]             asid,
    input  wire [18:0]            probe_vpn2,
    input  wire                   wr_en,
    input  wire [`TLB_IDX_W-1:0]  wr_index,
    input  wire tlb_entry_t       wr_entry,
    input  wire [`TLB_IDX_W-1:0]  rd_index,
    output tlb_result_t           lookup,
    output tlb_result_t           probe,
    output tlb_entry_t            rd_entry
);

    tlb_entry_t         entries [`TLBNUM];
    logic [`TLBNUM-1:0] loaded;
    logic [`TLBNUM-1:0] lookup_match;
    logic [`TLBNUM-1:0] probe_match;

    // an entry takes part in matching only once it has been written
    always_ff @(posedge clk) begin
        if (reset) begin
            loaded <= '0;
        end else if (wr_en) begin
            loaded[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    // global entries ignore the asid
    function automatic logic entry_match(
        input tlb_entry_t  e,
        input logic [18:0] vpn2,
        input logic [7:0]  cur_asid
    );
        return e.vpn2 == vpn2 && (e.g || e.asid == cur_asid);
    endfunction

    function automatic tlb_result_t encode(
        input logic [`TLBNUM-1:0] match,
        input logic               odd
    );
        tlb_result_t r;
        r = '0;
        for (int i = 0; i < `TLBNUM; i++) begin
            if (match[i]) begin
                r.hit   = 1'b1;
                r.index = i[`TLB_IDX_W-1:0];
                r.pfn   = entries[i].lo[odd].pfn;
                r.c     = entries[i].lo[odd].c;
                r.d     = entries[i].lo[odd].d;
                r.v     = entries[i].lo[odd].v;
            end
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < `TLBNUM; i++) begin
            lookup_match[i] = loaded[i] && entry_match(entries[i], vaddr[31:13], asid);
            probe_match[i]  = loaded[i] && entry_match(entries[i], probe_vpn2, asid);
        end
    end

    // vaddr bit 12 picks the odd page
    always_comb begin
        lookup = encode(lookup_match, vaddr[12]);
    end

    // probe only needs hit and index
    always_comb begin
        probe = encode(probe_match, 1'b0);
    end

    assign rd_entry = entries[rd_index];

    // two loaded entries covering one page would be a software fault
    a_single_hit: assert property (@(posedge clk) disable iff (reset)
        $onehot0(lookup_match));

endmodule

`default_nettype wire

// ==== exc_prioritizer.sv ====
`default_nettype none

`include "cp0_defs.svh"

module exc_prioritizer
    import cp0_pkg::*;
(
    input  wire mem_req_t     mem,
    input  wire [31:0]        pc,
    input  wire               delay_slot,
    input  wire               eret,
    input  wire tlb_result_t  lookup,
    output exc_event_t        exc_event,
    output logic [31:0]       paddr
);

    logic mapped;
    logic misaligned;
    logic tlb_fault;
    logic mod_fault;

    // kseg0 and kseg1 are 0x8000_0000..0xbfff_ffff, the rest is mapped
    assign mapped     = mem.vaddr[31:30] != 2'b10;
    assign misaligned = mem.size_word && mem.vaddr[1:0] != 2'b00;
    assign tlb_fault  = mapped && !(lookup.hit && lookup.v);
    assign mod_fault  = mapped && mem.store && !lookup.d;

    always_comb begin
        exc_event            = '0;
        exc_event.badvaddr   = mem.vaddr;
        exc_event.vpn2       = mem.vaddr[31:13];
        exc_event.pc         = pc;
        exc_event.delay_slot = delay_slot;
        if (mem.valid && misaligned) begin
            exc_event.valid   = 1'b1;
            exc_event.exccode = mem.store ? `EXC_ADES : `EXC_ADEL;
        end else if (mem.valid && tlb_fault) begin
            // refill and invalid share one code here
            exc_event.valid   = 1'b1;
            exc_event.exccode = mem.store ? `EXC_TLBS : `EXC_TLBL;
        end else if (mem.valid && mod_fault) begin
            exc_event.valid   = 1'b1;
            exc_event.exccode = `EXC_MOD;
        end else if (eret) begin
            exc_event.valid = 1'b1;
            exc_event.eret  = 1'b1;
        end
    end

    assign paddr = mapped ? {lookup.pfn, mem.vaddr[11:0]} : {3'b000, mem.vaddr[28:0]};

endmodule

`default_nettype wire

// ==== cp0_mmu_top.sv ====
`default_nettype none

`include "cp0_defs.svh"

module cp0_mmu_top
    import cp0_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire cp0_access_t  cp0_acc,
    input  wire tlb_op_t      tlb_op,
    input  wire mem_req_t     mem,
    input  wire [31:0]        pc,
    input  wire               delay_slot,
    input  wire               eret,
    input  wire [5:0]         interrupt,
    output logic [31:0]       rdata,
    output logic [31:0]       paddr,
    output logic              exception_now,
    output logic              eret_now,
    output logic [31:0]       epc,
    output logic [7:0]        cause_ip,
    output logic              status_exl
);

    tlb_result_t           lookup;
    tlb_result_t           probe;
    tlb_entry_t            rd_entry;
    tlb_entry_t            wr_entry;
    logic                  wr_en;
    logic [`TLB_IDX_W-1:0] tlb_index;
    logic [7:0]            asid;
    exc_event_t            exc_event;

    cp0_regs u_regs (
        .clk           (clk),
        .reset         (reset),
        .acc           (cp0_acc),
        .exc_event     (exc_event),
        .interrupt     (interrupt),
        .tlb_op        (tlb_op),
        .probe         (probe),
        .rd_entry      (rd_entry),
        .rdata         (rdata),
        .epc           (epc),
        .status_exl    (status_exl),
        .status_ie     (),
        .status_im     (),
        .cause_ip      (cause_ip),
        .asid          (asid),
        .wr_entry      (wr_entry),
        .wr_en         (wr_en),
        .tlb_index     (tlb_index),
        .exception_now (exception_now),
        .eret_now      (eret_now)
    );

    // tlbp compares the staged entryhi
    tlb u_tlb (
        .clk        (clk),
        .reset      (reset),
        .vaddr      (mem.vaddr),
        .asid       (asid),
        .probe_vpn2 (wr_entry.vpn2),
        .wr_en      (wr_en),
        .wr_index   (tlb_index),
        .wr_entry   (wr_entry),
        .rd_index   (tlb_index),
        .lookup     (lookup),
        .probe      (probe),
        .rd_entry   (rd_entry)
    );

    exc_prioritizer u_exc (
        .mem        (mem),
        .pc         (pc),
        .delay_slot (delay_slot),
        .eret       (eret),
        .lookup     (lookup),
        .exc_event  (exc_event),
        .paddr      (paddr)
    );

endmodule

`default_nettype wire

// ==== tb_cp0_mmu.sv ====
`default_nettype none

`include "cp0_defs.svh"

module tb_cp0_mmu
    import cp0_pkg::*;
();

    logic        clk;
    logic        reset;
    cp0_access_t cp0_acc;
    tlb_op_t     tlb_op;
    mem_req_t    mem;
    logic [31:0] pc;
    logic        delay_slot;
    logic        eret;
    logic [5:0]  interrupt;
    logic [31:0] rdata;
    logic [31:0] paddr;
    logic        exception_now;
    logic        eret_now;
    logic [31:0] epc;
    logic [7:0]  cause_ip;
    logic        status_exl;

    integer seed;
    int     error_count;
    int     check_count;
    int     timeout_count;

    cp0_mmu_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .cp0_acc       (cp0_acc),
        .tlb_op        (tlb_op),
        .mem           (mem),
        .pc            (pc),
        .delay_slot    (delay_slot),
        .eret          (eret),
        .interrupt     (interrupt),
        .rdata         (rdata),
        .paddr         (paddr),
        .exception_now (exception_now),
        .eret_now      (eret_now),
        .epc           (epc),
        .cause_ip      (cause_ip),
        .status_exl    (status_exl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    // smallest field value f with base << f reaching n
    function automatic logic [2:0] size_field(input int n, input int base);
        logic [2:0] f;
        f = 3'd0;
        while ((base << f) < n && f != 3'd7) begin
            f++;
        end
        return f;
    endfunction

    // mips32 config1 layout of the cache and tlb geometry
    function automatic logic [31:0] config1_expected();
        logic [31:0] expected;
        expected = 32'(`TLBNUM - 1) << 25;
        expected |= 32'(size_field(`I_LINES, 64)) << 22;
        expected |= 32'(size_field(`I_LINE_BYTES, 2)) << 19;
        expected |= 32'(`I_WAYS - 1) << 16;
        expected |= 32'(size_field(`D_LINES, 64)) << 13;
        expected |= 32'(size_field(`D_LINE_BYTES, 2)) << 10;
        expected |= 32'(`D_WAYS - 1) << 7;
        return expected;
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    function automatic exc_event_t make_event(input logic [4:0] code,
                                              input logic [31:0] vaddr,
                                              input logic [31:0] at_pc, input logic ds);
        exc_event_t e;
        e            = '0;
        e.valid      = 1'b1;
        e.exccode    = code;
        e.badvaddr   = vaddr;
        e.vpn2       = vaddr[31:13];
        e.pc         = at_pc;
        e.delay_slot = ds;
        return e;
    endfunction

    task automatic read_reg(input logic [4:0] num, input logic [2:0] sel,
                            output logic [31:0] data);
        @(negedge clk);
        cp0_acc = '{reg_num: num, sel: sel, wen: 1'b0, wdata: 32'h0};
        #10;
        data = rdata;
    endtask

    task automatic write_reg(input logic [4:0] num, input logic [2:0] sel,
                             input logic [31:0] data);
        @(negedge clk);
        cp0_acc = '{reg_num: num, sel: sel, wen: 1'b1, wdata: data};
        @(negedge clk);
        cp0_acc.wen = 1'b0;
    endtask

    task automatic tlb_cmd(input tlb_op_t op);
        @(negedge clk);
        tlb_op = op;
        @(negedge clk);
        tlb_op = '0;
    endtask

    task automatic write_entry(input logic [3:0] idx, input logic [18:0] vpn2,
                               input logic [7:0] asid, input logic [31:0] lo0,
                               input logic [31:0] lo1);
        write_reg(`CP0_ENTRYHI, 3'd0, {vpn2, 5'b0, asid});
        write_reg(`CP0_ENTRYLO0, 3'd0, lo0);
        write_reg(`CP0_ENTRYLO1, 3'd0, lo1);
        write_reg(`CP0_INDEX, 3'd0, {28'b0, idx});
        tlb_cmd('{probe: 1'b0, read: 1'b0, write_indexed: 1'b1});
    endtask

    // one-cycle data access with the result sampled mid-cycle
    task automatic mem_access(input logic store, input logic word, input logic [31:0] vaddr,
                              input logic [31:0] at_pc, input logic ds, input logic exc_exp,
                              output logic [31:0] pa);
        @(negedge clk);
        mem        = '{valid: 1'b1, store: store, size_word: word, vaddr: vaddr};
        pc         = at_pc;
        delay_slot = ds;
        #10;
        pa = paddr;
        check_bit("exception_now", exception_now, exc_exp);
        @(negedge clk);
        mem.valid  = 1'b0;
        delay_slot = 1'b0;
    endtask

    task automatic check_event(input string name, input exc_event_t exp);
        logic [31:0] cause;
        logic [31:0] value;
        logic [31:0] epc_exp;
        epc_exp = exp.delay_slot ? exp.pc - 32'd4 : exp.pc;
        read_reg(`CP0_CAUSE, 3'd0, cause);
        check_word({name, " cause.exccode"}, {27'b0, cause[6:2]}, {27'b0, exp.exccode});
        check_bit({name, " cause.bd"}, cause[31], exp.delay_slot);
        read_reg(`CP0_BADVADDR, 3'd0, value);
        check_word({name, " badvaddr"}, value, exp.badvaddr);
        read_reg(`CP0_EPC, 3'd0, value);
        check_word({name, " epc"}, value, epc_exp);
        check_word({name, " epc port"}, epc, epc_exp);
        // only tlb faults load entryhi
        if (exp.exccode inside {`EXC_TLBL, `EXC_TLBS, `EXC_MOD}) begin
            read_reg(`CP0_ENTRYHI, 3'd0, value);
            check_word({name, " entryhi.vpn2"}, {13'b0, value[31:13]}, {13'b0, exp.vpn2});
        end
    endtask

    task automatic register_port();
        logic [31:0] value;
        logic [31:0] wdata;
        logic [2:0]  k0;
        read_reg(`CP0_STATUS, 3'd0, value);
        check_bit("status.ie after reset", value[0], 1'b0);
        check_bit("status.exl after reset", value[1], 1'b0);
        read_reg(`CP0_INDEX, 3'd0, value);
        check_bit("index.p after reset", value[31], 1'b0);
        read_reg(`CP0_CONFIG, 3'd0, value);
        check_word("config.k0 after reset", {29'b0, value[2:0]}, 32'd2);
        repeat (4) begin
            wdata = $random(seed);
            write_reg(`CP0_ENTRYHI, 3'd0, wdata);
            read_reg(`CP0_ENTRYHI, 3'd0, value);
            check_word("entryhi", value, wdata & 32'hffff_e0ff);
            wdata = $random(seed);
            write_reg(`CP0_ENTRYLO0, 3'd0, wdata);
            read_reg(`CP0_ENTRYLO0, 3'd0, value);
            check_word("entrylo0", value, wdata & 32'h03ff_ffff);
            wdata = $random(seed);
            write_reg(`CP0_ENTRYLO1, 3'd0, wdata);
            read_reg(`CP0_ENTRYLO1, 3'd0, value);
            check_word("entrylo1", value, wdata & 32'h03ff_ffff);
            wdata = $random(seed);
            write_reg(`CP0_INDEX, 3'd0, wdata);
            read_reg(`CP0_INDEX, 3'd0, value);
            check_word("index", value, wdata & 32'h0000_000f);
            wdata = $random(seed);
            write_reg(`CP0_EPC, 3'd0, wdata);
            read_reg(`CP0_EPC, 3'd0, value);
            check_word("epc", value, wdata);
            wdata = $random(seed);
            write_reg(`CP0_STATUS, 3'd0, wdata);
            read_reg(`CP0_STATUS, 3'd0, value);
            // bev is read-only
            check_word("status", value & 32'hffbf_ffff, wdata & 32'h0000_ff03);
            wdata = $random(seed);
            write_reg(`CP0_COMPARE, 3'd0, wdata);
            read_reg(`CP0_COMPARE, 3'd0, value);
            check_word("compare", value, wdata);
        end
        write_reg(`CP0_STATUS, 3'd0, 32'h0);
        wdata = $random(seed);
        // k0 must move away from its reset value
        k0 = (wdata[2:0] == 3'd2) ? 3'd3 : wdata[2:0];
        write_reg(`CP0_CONFIG, 3'd0, {29'b0, k0});
        read_reg(`CP0_CONFIG, 3'd0, value);
        check_word("config.k0", {29'b0, value[2:0]}, {29'b0, k0});
        read_reg(`CP0_CONFIG, 3'd1, value);
        check_word("config1", value, config1_expected());
        for (int num = 0; num < 32; num++) begin
            if (!(5'(num) inside {`CP0_INDEX, `CP0_ENTRYLO0, `CP0_ENTRYLO1, `CP0_BADVADDR,
                                  `CP0_COUNT, `CP0_ENTRYHI, `CP0_COMPARE, `CP0_STATUS,
                                  `CP0_CAUSE, `CP0_EPC, `CP0_CONFIG})) begin
                read_reg(5'(num), 3'd0, value);
                check_word($sformatf("unimplemented reg %0d", num), value, 32'h0);
            end
        end
    endtask

    task automatic tlb_staging();
        logic [31:0] r;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [31:0] lo0;
        logic [31:0] lo1;
        logic [31:0] value;
        r    = $random(seed);
        vpn2 = {2'b11, r[16:0]};
        asid = r[24:17];
        g    = r[31];
        lo0  = ($random(seed) & 32'h03ff_fffe) | {31'b0, g};
        lo1  = ($random(seed) & 32'h03ff_fffe) | {31'b0, g};
        write_entry(4'd5, vpn2, asid, lo0, lo1);
        write_reg(`CP0_ENTRYHI, 3'd0, 32'h0);
        write_reg(`CP0_ENTRYLO0, 3'd0, 32'h0);
        write_reg(`CP0_ENTRYLO1, 3'd0, 32'h0);
        tlb_cmd('{probe: 1'b0, read: 1'b1, write_indexed: 1'b0});
        read_reg(`CP0_ENTRYHI, 3'd0, value);
        check_word("entryhi after tlbr", value, {vpn2, 5'b0, asid});
        read_reg(`CP0_ENTRYLO0, 3'd0, value);
        check_word("entrylo0 after tlbr", value, lo0);
        read_reg(`CP0_ENTRYLO1, 3'd0, value);
        check_word("entrylo1 after tlbr", value, lo1);
        // absent vpn2 first so the hit has to clear p and load the index
        write_reg(`CP0_ENTRYHI, 3'd0, {vpn2 ^ 19'h1, 5'b0, asid});
        tlb_cmd('{probe: 1'b1, read: 1'b0, write_indexed: 1'b0});
        read_reg(`CP0_INDEX, 3'd0, value);
        check_bit("index.p after tlbp miss", value[31], 1'b1);
        write_reg(`CP0_INDEX, 3'd0, 32'h0);
        write_reg(`CP0_ENTRYHI, 3'd0, {vpn2, 5'b0, asid});
        tlb_cmd('{probe: 1'b1, read: 1'b0, write_indexed: 1'b0});
        read_reg(`CP0_INDEX, 3'd0, value);
        check_word("index after tlbp hit", value, 32'h0000_0005);
    endtask

    task automatic mapped_translation();
        logic [31:0] pa;
        // even page dirty and odd page clean
        write_entry(4'd1, 19'h00040, 8'h12, make_lo(20'h12345, 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(20'h54321, 3'd3, 1'b0, 1'b1, 1'b0));
        write_entry(4'd2, 19'h00041, 8'h12, make_lo(20'h0abcd, 3'd2, 1'b1, 1'b0, 1'b0),
                    make_lo(20'h0dcba, 3'd2, 1'b1, 1'b0, 1'b0));
        mem_access(1'b0, 1'b1, 32'h0008_0ab8, 32'h0000_1000, 1'b0, 1'b0, pa);
        check_word("paddr even page", pa, 32'h1234_5ab8);
        mem_access(1'b0, 1'b1, 32'h0008_1ff0, 32'h0000_1000, 1'b0, 1'b0, pa);
        check_word("paddr odd page", pa, 32'h5432_1ff0);
        mem_access(1'b0, 1'b1, 32'h8012_3450, 32'h0000_1000, 1'b0, 1'b0, pa);
        check_word("paddr kseg0", pa, 32'h0012_3450);
        mem_access(1'b0, 1'b1, 32'ha0ff_0010, 32'h0000_1000, 1'b0, 1'b0, pa);
        check_word("paddr kseg1", pa, 32'h00ff_0010);
        mem_access(1'b0, 1'b1, 32'h0040_0010, 32'h0000_1000, 1'b0, 1'b1, pa);
        check_event("tlbl", make_event(`EXC_TLBL, 32'h0040_0010, 32'h0000_1000, 1'b0));
        write_reg(`CP0_STATUS, 3'd0, 32'h0);
        mem_access(1'b1, 1'b1, 32'h0008_2008, 32'h0000_1004, 1'b0, 1'b1, pa);
        check_event("tlbs", make_event(`EXC_TLBS, 32'h0008_2008, 32'h0000_1004, 1'b0));
        write_reg(`CP0_STATUS, 3'd0, 32'h0);
        mem_access(1'b1, 1'b1, 32'h0008_1004, 32'h0000_1008, 1'b0, 1'b1, pa);
        check_event("mod", make_event(`EXC_MOD, 32'h0008_1004, 32'h0000_1008, 1'b0));
        write_reg(`CP0_STATUS, 3'd0, 32'h0);
    endtask

    task automatic address_errors();
        logic [31:0] pa;
        logic [31:0] value;
        mem_access(1'b0, 1'b1, 32'h0008_0002, 32'h0000_2000, 1'b0, 1'b1, pa);
        check_event("adel", make_event(`EXC_ADEL, 32'h0008_0002, 32'h0000_2000, 1'b0));
        write_reg(`CP0_STATUS, 3'd0, 32'h0);
        mem_access(1'b1, 1'b1, 32'h0000_0101, 32'h0000_2104, 1'b1, 1'b1, pa);
        check_event("ades in delay slot",
                    make_event(`EXC_ADES, 32'h0000_0101, 32'h0000_2104, 1'b1));
        check_bit("status_exl", status_exl, 1'b1);
        // nested fault while exl is set
        mem_access(1'b0, 1'b1, 32'h0000_0203, 32'h0000_3000, 1'b0, 1'b1, pa);
        read_reg(`CP0_EPC, 3'd0, value);
        check_word("epc nested", value, 32'h0000_2100);
        read_reg(`CP0_CAUSE, 3'd0, value);
        check_word("cause.exccode nested", {27'b0, value[6:2]}, {27'b0, `EXC_ADEL});
        check_bit("cause.bd nested", value[31], 1'b1);
        read_reg(`CP0_BADVADDR, 3'd0, value);
        check_word("badvaddr nested", value, 32'h0000_0203);
        @(negedge clk);
        eret = 1'b1;
        #10;
        check_bit("eret_now", eret_now, 1'b1);
        check_bit("exception_now during eret", exception_now, 1'b0);
        @(negedge clk);
        eret = 1'b0;
        #10;
        check_bit("status_exl after eret", status_exl, 1'b0);
        check_bit("eret_now after eret", eret_now, 1'b0);
    endtask

    task automatic timer_interrupt();
        logic [31:0] c0;
        logic [31:0] c1;
        logic [31:0] value;
        logic        seen;
        int          waited;
        read_reg(`CP0_COUNT, 3'd0, c0);
        write_reg(`CP0_COMPARE, 3'd0, c0 + 32'd20);
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < 200) begin
            @(negedge clk);
            #10;
            seen = cause_ip[7];
            waited++;
        end
        if (!seen) begin
            timeout_count++;
            $display("timeout: timer interrupt did not reach cause_ip[7] in %0d cycles", waited);
        end
        read_reg(`CP0_CAUSE, 3'd0, value);
        check_bit("cause.ti set", value[30], 1'b1);
        write_reg(`CP0_COMPARE, 3'd0, c0 + 32'h4000_0000);
        read_reg(`CP0_CAUSE, 3'd0, value);
        check_bit("cause.ti after compare write", value[30], 1'b0);
        check_bit("cause_ip[7] after compare write", cause_ip[7], 1'b0);
        // 40 cycles apart
        read_reg(`CP0_COUNT, 3'd0, c0);
        repeat (39) @(negedge clk);
        read_reg(`CP0_COUNT, 3'd0, c1);
        check_word("count advance", c1 - c0, 32'd20);
    endtask

    initial begin
        seed          = 32'h5f21_f22d;
        error_count   = 0;
        check_count   = 0;
        timeout_count = 0;
        reset         = 1'b1;
        cp0_acc       = '0;
        tlb_op        = '0;
        mem           = '0;
        pc            = '0;
        delay_slot    = 1'b0;
        eret          = 1'b0;
        interrupt     = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset           = 1'b0;
        cp0_acc.reg_num = `CP0_COUNT;
        #10;
        check_word("count after reset", rdata, 32'h0);
        check_bit("exception_now after reset", exception_now, 1'b0);
        check_bit("status_exl after reset", status_exl, 1'b0);
        register_port();
        tlb_staging();
        mapped_translation();
        address_errors();
        timer_interrupt();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
cp0_pkg.sv
cp0_regs.sv
tlb.sv
exc_prioritizer.sv
cp0_mmu_top.sv
tb_cp0_mmu.sv
